//--- hw/cry_isa_pkg.sv
`default_nettype none

package cry_isa_pkg;

    typedef enum logic [3:0] {
        op_sha_sum0 = 4'd0,
        op_sha_sum1 = 4'd1,
        op_sha_sig0 = 4'd2,
        op_sha_sig1 = 4'd3,
        op_ror      = 4'd4,
        op_rol      = 4'd5,
        op_aes_esi  = 4'd6,
        op_aes_esmi = 4'd7
    } cry_op_t;

    typedef enum logic [2:0] {
        alu_sum0 = 3'd0,
        alu_sum1 = 3'd1,
        alu_sig0 = 3'd2,
        alu_sig1 = 3'd3,
        alu_ror  = 3'd4,
        alu_rol  = 3'd5,
        alu_none = 3'd7
    } alu_sel_t;

    typedef enum logic {
        aes_mode_esi  = 1'b0,
        aes_mode_esmi = 1'b1
    } aes_mode_t;

    // multiply by x, reduced by x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] gf_xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] aa;
        p  = 8'h00;
        aa = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ aa;
            end
            aa = gf_xtime(aa);
        end
        return p;
    endfunction

    // inverse as x^254, then the affine map
    function automatic logic [7:0] aes_sbox(input logic [7:0] x);
        logic [7:0] sq;
        logic [7:0] inv;
        sq  = x;
        inv = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);
            inv = gf_mul(inv, sq);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

endpackage

`default_nettype wire

//--- hw/cry_cfg_pkg.sv
`default_nettype none

package cry_cfg_pkg;

    // threads in one warp
    localparam int num_threads = 4;

    localparam int nw_bits = 2;
    localparam int nr_bits = 5;

    // data and pc width
    localparam int xlen = 32;

    // one word per thread
    typedef logic [num_threads-1:0][xlen-1:0] lane_data_t;

    typedef logic [num_threads-1:0] tmask_t;

endpackage

`default_nettype wire

//--- hw/cry_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module cry_pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic enable,
    input  wire logic valid_in,
    output logic      valid_out,
    input  payload_t  data_in,
    output payload_t  data_out
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else if (enable) begin
            valid_out <= valid_in;
        end
    end

    // payload follows the valid bit
    always_ff @(posedge clk) begin
        if (enable) begin
            data_out <= data_in;
        end
    end

endmodule

`default_nettype wire

//--- hw/cry_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cry_req_decode (
    input  wire logic                    req_valid,
    input  cry_isa_pkg::cry_op_t         req_op,
    input  wire logic                    aes_ready,
    input  wire logic                    alu_ready,
    output logic                         aes_valid,
    output cry_isa_pkg::aes_mode_t       aes_mix,
    output logic                         alu_valid,
    output cry_isa_pkg::alu_sel_t        alu_sel,
    output logic                         req_ready
);

    import cry_isa_pkg::*;

    logic is_aes;

    assign is_aes = (req_op == op_aes_esi) || (req_op == op_aes_esmi);

    assign aes_mix = (req_op == op_aes_esmi) ? aes_mode_esmi : aes_mode_esi;

    // exactly one path sees a valid request
    assign aes_valid = req_valid && is_aes;
    assign alu_valid = req_valid && !is_aes;

    always_comb begin
        case (req_op)
            op_sha_sum0: alu_sel = alu_sum0;
            op_sha_sum1: alu_sel = alu_sum1;
            op_sha_sig0: alu_sel = alu_sig0;
            op_sha_sig1: alu_sel = alu_sig1;
            op_ror:      alu_sel = alu_ror;
            op_rol:      alu_sel = alu_rol;
            // illegal codes end up here too
            default:     alu_sel = alu_none;
        endcase
    end

    assign req_ready = is_aes ? aes_ready : alu_ready;

endmodule

`default_nettype wire

//--- hw/cry_sha_rot_unit.sv
`timescale 1ns/1ps
`default_nettype none

module cry_sha_rot_unit (
    input  cry_isa_pkg::alu_sel_t   alu_sel,
    input  wire logic               req_use_imm,
    input  wire logic [4:0]         req_imm,
    input  cry_cfg_pkg::lane_data_t rs1,
    input  cry_cfg_pkg::lane_data_t rs2,
    output cry_cfg_pkg::lane_data_t alu_result
);

    import cry_isa_pkg::*;
    import cry_cfg_pkg::*;

    function automatic logic [xlen-1:0] rot_r(input logic [xlen-1:0] a, input logic [4:0] n);
        logic [2*xlen-1:0] dbl;
        dbl = {a, a} >> n;
        return dbl[xlen-1:0];
    endfunction

    for (genvar i = 0; i < num_threads; i++) begin : g_lane
        logic [4:0]      shamt;
        logic [xlen-1:0] a;

        assign a     = rs1[i];
        assign shamt = req_use_imm ? req_imm : rs2[i][4:0];

        always_comb begin
            case (alu_sel)
                alu_sum0: alu_result[i] = rot_r(a, 5'd2) ^ rot_r(a, 5'd13) ^ rot_r(a, 5'd22);
                alu_sum1: alu_result[i] = rot_r(a, 5'd6) ^ rot_r(a, 5'd11) ^ rot_r(a, 5'd25);
                alu_sig0: alu_result[i] = rot_r(a, 5'd7) ^ rot_r(a, 5'd18) ^ (a >> 3);
                alu_sig1: alu_result[i] = rot_r(a, 5'd17) ^ rot_r(a, 5'd19) ^ (a >> 10);
                alu_ror:  alu_result[i] = rot_r(a, shamt);
                // left by n is right by 32 - n
                alu_rol:  alu_result[i] = rot_r(a, 5'd0 - shamt);
                default:  alu_result[i] = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/cry_aes_unit.sv
`timescale 1ns/1ps
`default_nettype none

module cry_aes_unit (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          aes_valid,
    input  cry_isa_pkg::aes_mode_t             aes_mix,
    output logic                               aes_ready,
    input  wire logic [1:0]                    bs,
    input  cry_cfg_pkg::lane_data_t            rs1,
    input  cry_cfg_pkg::lane_data_t            rs2,
    input  wire logic [cry_cfg_pkg::nw_bits-1:0] wid,
    input  cry_cfg_pkg::tmask_t                tmask,
    input  wire logic [cry_cfg_pkg::xlen-1:0]  pc,
    input  wire logic [cry_cfg_pkg::nr_bits-1:0] rd,
    input  wire logic                          wb,
    output logic                               aes_out_valid,
    input  wire logic                          aes_out_ready,
    output logic [cry_cfg_pkg::nw_bits-1:0]    out_wid,
    output cry_cfg_pkg::tmask_t                out_tmask,
    output logic [cry_cfg_pkg::xlen-1:0]       out_pc,
    output logic [cry_cfg_pkg::nr_bits-1:0]    out_rd,
    output logic                               out_wb,
    output cry_cfg_pkg::lane_data_t            aes_result
);

    import cry_isa_pkg::*;
    import cry_cfg_pkg::*;

    typedef struct packed {
        logic [nw_bits-1:0] wid;
        tmask_t             tmask;
        logic [xlen-1:0]    pc;
        logic [nr_bits-1:0] rd;
        logic               wb;
    } meta_t;

    typedef struct packed {
        logic [num_threads-1:0][7:0] sbox;
        lane_data_t                  rs1;
        aes_mode_t                   mix;
        logic [1:0]                  bs;
        meta_t                       meta;
    } s1_t;

    typedef struct packed {
        lane_data_t result;
        meta_t      meta;
    } s2_t;

    function automatic logic [xlen-1:0] rol_bytes(input logic [xlen-1:0] w,
                                                   input logic [1:0] n);
        logic [2*xlen-1:0] dbl;
        dbl = {w, w} << {n, 3'b000};
        return dbl[2*xlen-1:xlen];
    endfunction

    s1_t  s1_in, s1_out;
    s2_t  s2_in, s2_out;
    logic s1_valid, s2_valid;
    logic s1_en, s2_en;

    // a stage moves when the one behind it is empty or draining
    assign s2_en     = !s2_valid || aes_out_ready;
    assign s1_en     = !s1_valid || s2_en;
    assign aes_ready = s1_en;

    for (genvar i = 0; i < num_threads; i++) begin : g_sub
        assign s1_in.sbox[i] = aes_sbox(rs2[i][{bs, 3'b000} +: 8]);
    end

    assign s1_in.rs1  = rs1;
    assign s1_in.mix  = aes_mix;
    assign s1_in.bs   = bs;
    assign s1_in.meta = '{wid: wid, tmask: tmask, pc: pc, rd: rd, wb: wb};

    cry_pipe_reg #(.payload_t(s1_t)) u_stage1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (s1_en),
        .valid_in  (aes_valid),
        .valid_out (s1_valid),
        .data_in   (s1_in),
        .data_out  (s1_out)
    );

    for (genvar i = 0; i < num_threads; i++) begin : g_mix
        logic [7:0]      s;
        logic [7:0]      s2x;
        logic [xlen-1:0] col;

        assign s   = s1_out.sbox[i];
        assign s2x = gf_xtime(s);
        // byte 3 is 3*s in the mixed column
        assign col = (s1_out.mix == aes_mode_esmi) ? {s2x ^ s, s, s, s2x} : {24'h0, s};
        assign s2_in.result[i] = s1_out.rs1[i] ^ rol_bytes(col, s1_out.bs);
    end

    assign s2_in.meta = s1_out.meta;

    cry_pipe_reg #(.payload_t(s2_t)) u_stage2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (s2_en),
        .valid_in  (s1_valid),
        .valid_out (s2_valid),
        .data_in   (s2_in),
        .data_out  (s2_out)
    );

    assign aes_out_valid = s2_valid;
    assign aes_result    = s2_out.result;
    assign out_wid       = s2_out.meta.wid;
    assign out_tmask     = s2_out.meta.tmask;
    assign out_pc        = s2_out.meta.pc;
    assign out_rd        = s2_out.meta.rd;
    assign out_wb        = s2_out.meta.wb;

endmodule

`default_nettype wire

//--- hw/cry_commit_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cry_commit_stage (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            alu_valid,
    input  cry_isa_pkg::alu_sel_t                alu_sel,
    input  cry_cfg_pkg::lane_data_t              alu_result,
    input  wire logic [cry_cfg_pkg::nw_bits-1:0] wid,
    input  cry_cfg_pkg::tmask_t                  tmask,
    input  wire logic [cry_cfg_pkg::xlen-1:0]    pc,
    input  wire logic [cry_cfg_pkg::nr_bits-1:0] rd,
    input  wire logic                            wb,
    input  wire logic                            aes_out_valid,
    input  wire logic [cry_cfg_pkg::nw_bits-1:0] aes_wid,
    input  cry_cfg_pkg::tmask_t                  aes_tmask,
    input  wire logic [cry_cfg_pkg::xlen-1:0]    aes_pc,
    input  wire logic [cry_cfg_pkg::nr_bits-1:0] aes_rd,
    input  wire logic                            aes_wb,
    input  cry_cfg_pkg::lane_data_t              aes_result,
    output logic                                 aes_out_ready,
    output logic                                 alu_ready,
    output logic                                 commit_valid,
    output logic [cry_cfg_pkg::nw_bits-1:0]      commit_wid,
    output cry_cfg_pkg::tmask_t                  commit_tmask,
    output logic [cry_cfg_pkg::xlen-1:0]         commit_pc,
    output logic [cry_cfg_pkg::nr_bits-1:0]      commit_rd,
    output logic                                 commit_wb,
    output cry_cfg_pkg::lane_data_t              commit_data,
    input  wire logic                            commit_ready
);

    import cry_isa_pkg::*;
    import cry_cfg_pkg::*;

    typedef struct packed {
        logic [nw_bits-1:0] wid;
        tmask_t             tmask;
        logic [xlen-1:0]    pc;
        logic [nr_bits-1:0] rd;
        logic               wb;
        lane_data_t         data;
    } commit_t;

    commit_t sel, held;
    logic    enable;

    // holds while the consumer stalls
    assign enable        = !(commit_valid && !commit_ready);
    assign aes_out_ready = enable;
    assign alu_ready     = enable && !aes_out_valid;

    // aes has priority
    always_comb begin
        if (aes_out_valid) begin
            sel = '{wid: aes_wid, tmask: aes_tmask, pc: aes_pc, rd: aes_rd,
                    wb: aes_wb, data: aes_result};
        end else begin
            sel = '{wid: wid, tmask: tmask, pc: pc, rd: rd,
                    wb: wb && (alu_sel != alu_none), data: alu_result};
        end
    end

    cry_pipe_reg #(.payload_t(commit_t)) u_commit_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .valid_in  (aes_out_valid || alu_valid),
        .valid_out (commit_valid),
        .data_in   (sel),
        .data_out  (held)
    );

    assign commit_wid   = held.wid;
    assign commit_tmask = held.tmask;
    assign commit_pc    = held.pc;
    assign commit_rd    = held.rd;
    assign commit_wb    = held.wb;
    assign commit_data  = held.data;

endmodule

`default_nettype wire

//--- hw/cry_unit.sv
`timescale 1ns/1ps
`default_nettype none

module cry_unit (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            req_valid,
    output logic                                 req_ready,
    input  cry_isa_pkg::cry_op_t                 req_op,
    input  wire logic [1:0]                      req_bs,
    input  wire logic                            req_use_imm,
    input  wire logic [4:0]                      req_imm,
    input  wire logic [cry_cfg_pkg::nw_bits-1:0] req_wid,
    input  cry_cfg_pkg::tmask_t                  req_tmask,
    input  wire logic [cry_cfg_pkg::xlen-1:0]    req_pc,
    input  wire logic [cry_cfg_pkg::nr_bits-1:0] req_rd,
    input  wire logic                            req_wb,
    input  cry_cfg_pkg::lane_data_t              req_rs1,
    input  cry_cfg_pkg::lane_data_t              req_rs2,
    output logic                                 commit_valid,
    input  wire logic                            commit_ready,
    output logic [cry_cfg_pkg::nw_bits-1:0]      commit_wid,
    output cry_cfg_pkg::tmask_t                  commit_tmask,
    output logic [cry_cfg_pkg::xlen-1:0]         commit_pc,
    output logic [cry_cfg_pkg::nr_bits-1:0]      commit_rd,
    output logic                                 commit_wb,
    output cry_cfg_pkg::lane_data_t              commit_data
);

    import cry_isa_pkg::*;
    import cry_cfg_pkg::*;

    logic               aes_valid, aes_ready;
    aes_mode_t          aes_mix;
    logic               alu_valid, alu_ready;
    alu_sel_t           alu_sel;
    lane_data_t         alu_result;
    logic               aes_out_valid, aes_out_ready;
    logic [nw_bits-1:0] aes_wid;
    tmask_t             aes_tmask;
    logic [xlen-1:0]    aes_pc;
    logic [nr_bits-1:0] aes_rd;
    logic               aes_wb;
    lane_data_t         aes_result;

    cry_req_decode u_decode (
        .req_valid (req_valid),
        .req_op    (req_op),
        .aes_ready (aes_ready),
        .alu_ready (alu_ready),
        .aes_valid (aes_valid),
        .aes_mix   (aes_mix),
        .alu_valid (alu_valid),
        .alu_sel   (alu_sel),
        .req_ready (req_ready)
    );

    cry_sha_rot_unit u_sha_rot (
        .alu_sel     (alu_sel),
        .req_use_imm (req_use_imm),
        .req_imm     (req_imm),
        .rs1         (req_rs1),
        .rs2         (req_rs2),
        .alu_result  (alu_result)
    );

    cry_aes_unit u_aes (
        .clk           (clk),
        .rst_n         (rst_n),
        .aes_valid     (aes_valid),
        .aes_mix       (aes_mix),
        .aes_ready     (aes_ready),
        .bs            (req_bs),
        .rs1           (req_rs1),
        .rs2           (req_rs2),
        .wid           (req_wid),
        .tmask         (req_tmask),
        .pc            (req_pc),
        .rd            (req_rd),
        .wb            (req_wb),
        .aes_out_valid (aes_out_valid),
        .aes_out_ready (aes_out_ready),
        .out_wid       (aes_wid),
        .out_tmask     (aes_tmask),
        .out_pc        (aes_pc),
        .out_rd        (aes_rd),
        .out_wb        (aes_wb),
        .aes_result    (aes_result)
    );

    cry_commit_stage u_commit (
        .clk           (clk),
        .rst_n         (rst_n),
        .alu_valid     (alu_valid),
        .alu_sel       (alu_sel),
        .alu_result    (alu_result),
        .wid           (req_wid),
        .tmask         (req_tmask),
        .pc            (req_pc),
        .rd            (req_rd),
        .wb            (req_wb),
        .aes_out_valid (aes_out_valid),
        .aes_wid       (aes_wid),
        .aes_tmask     (aes_tmask),
        .aes_pc        (aes_pc),
        .aes_rd        (aes_rd),
        .aes_wb        (aes_wb),
        .aes_result    (aes_result),
        .aes_out_ready (aes_out_ready),
        .alu_ready     (alu_ready),
        .commit_valid  (commit_valid),
        .commit_wid    (commit_wid),
        .commit_tmask  (commit_tmask),
        .commit_pc     (commit_pc),
        .commit_rd     (commit_rd),
        .commit_wb     (commit_wb),
        .commit_data   (commit_data),
        .commit_ready  (commit_ready)
    );

endmodule

`default_nettype wire

//--- test/cry_unit_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cry_unit_properties (
    input wire logic                            clk,
    input wire logic                            rst_n,
    input wire logic                            req_valid,
    input wire logic                            req_ready,
    input wire logic [3:0]                      req_op,
    input wire logic                            commit_valid,
    input wire logic                            commit_ready,
    input wire logic [cry_cfg_pkg::nw_bits-1:0] commit_wid,
    input wire cry_cfg_pkg::tmask_t             commit_tmask,
    input wire logic [cry_cfg_pkg::xlen-1:0]    commit_pc,
    input wire logic [cry_cfg_pkg::nr_bits-1:0] commit_rd,
    input wire logic                            commit_wb,
    input wire cry_cfg_pkg::lane_data_t         commit_data
);

    import cry_isa_pkg::*;

    logic alu_req;

    assign alu_req = req_valid && (req_op != op_aes_esi) && (req_op != op_aes_esmi);

    // commit port frozen during a stall
    a_commit_hold: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_wid)
            && $stable(commit_tmask) && $stable(commit_pc) && $stable(commit_rd)
            && $stable(commit_wb) && $stable(commit_data))
        else $error("commit port changed while stalled");

    a_alu_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_ready && alu_req |-> !req_ready)
        else $error("ALU request accepted while the commit register was stalled");

    a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !commit_valid)
        else $error("commit_valid high right after reset release");

endmodule

bind cry_unit cry_unit_properties u_properties (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req_op       (req_op),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_wid   (commit_wid),
    .commit_tmask (commit_tmask),
    .commit_pc    (commit_pc),
    .commit_rd    (commit_rd),
    .commit_wb    (commit_wb),
    .commit_data  (commit_data)
);

`default_nettype wire

//--- test/cry_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cry_unit_tb;

    import cry_isa_pkg::*;
    import cry_cfg_pkg::*;

    typedef struct packed {
        lane_data_t         data;
        logic [nw_bits-1:0] wid;
        tmask_t             tmask;
        logic [nr_bits-1:0] rd;
        logic               wb;
    } exp_t;

    logic               clk, rst_n;
    logic               req_valid, req_ready, req_use_imm, req_wb;
    cry_op_t            req_op;
    logic [1:0]         req_bs;
    logic [4:0]         req_imm;
    logic [nw_bits-1:0] req_wid, commit_wid;
    tmask_t             req_tmask, commit_tmask;
    logic [xlen-1:0]    req_pc, commit_pc;
    logic [nr_bits-1:0] req_rd, commit_rd;
    lane_data_t         req_rs1, req_rs2, commit_data;
    logic               commit_valid, commit_ready, commit_wb;

    integer          seed = 32'he73b;
    bit              backpressure;
    string           cur_test;
    logic [xlen-1:0] next_pc;
    int              accept_wait;
    logic [7:0]      sbox_tab [256];
    exp_t            expected [logic [xlen-1:0]];
    string           exp_name [logic [xlen-1:0]];

    cry_unit u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic logic [31:0] rol32(input logic [31:0] x, input int n);
        return (x << n) | (x >> (32 - n));
    endfunction

    // carry-less product reduced modulo 0x11b
    function automatic logic [7:0] gf_times(input logic [7:0] a, input logic [7:0] b);
        logic [15:0] p;
        p = '0;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ (16'(a) << i);
            end
        end
        for (int i = 15; i >= 8; i--) begin
            if (p[i]) begin
                p = p ^ (16'h011b << (i - 8));
            end
        end
        return p[7:0];
    endfunction

    // inverse by search, then the affine map
    task automatic build_sbox();
        logic [7:0] inv;
        logic [7:0] b;
        for (int x = 0; x < 256; x++) begin
            inv = 8'h00;
            for (int y = 1; y < 256; y++) begin
                if (gf_times(8'(x), 8'(y)) == 8'h01) begin
                    inv = 8'(y);
                end
            end
            for (int i = 0; i < 8; i++) begin
                b[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
                       ^ inv[(i + 7) % 8];
            end
            sbox_tab[x] = b ^ 8'h63;
        end
    endtask

    function automatic bit is_legal_op(input cry_op_t op);
        case (op)
            op_sha_sum0, op_sha_sum1, op_sha_sig0, op_sha_sig1: return 1'b1;
            op_ror, op_rol, op_aes_esi, op_aes_esmi:            return 1'b1;
            default:                                             return 1'b0;
        endcase
    endfunction

    function automatic lane_data_t cry_ref_result(input cry_op_t op, input logic [1:0] bs,
                                                  input logic use_imm, input logic [4:0] imm,
                                                  input lane_data_t rs1, input lane_data_t rs2);
        lane_data_t  r;
        logic [31:0] x;
        logic [31:0] col;
        logic [7:0]  s;
        int          n;
        r = '0;
        for (int i = 0; i < num_threads; i++) begin
            x   = rs1[i];
            n   = use_imm ? imm : rs2[i][4:0];
            s   = sbox_tab[rs2[i][8*bs +: 8]];
            col = (op == op_aes_esmi) ? {gf_times(s, 8'h03), s, s, gf_times(s, 8'h02)}
                                      : {24'h0, s};
            case (op)
                op_sha_sum0: r[i] = ror32(x, 2) ^ ror32(x, 13) ^ ror32(x, 22);
                op_sha_sum1: r[i] = ror32(x, 6) ^ ror32(x, 11) ^ ror32(x, 25);
                op_sha_sig0: r[i] = ror32(x, 7) ^ ror32(x, 18) ^ (x >> 3);
                op_sha_sig1: r[i] = ror32(x, 17) ^ ror32(x, 19) ^ (x >> 10);
                op_ror:      r[i] = ror32(x, n);
                op_rol:      r[i] = rol32(x, n);
                op_aes_esi, op_aes_esmi: r[i] = x ^ rol32(col, 8 * bs);
                default:     r[i] = '0;
            endcase
        end
        return r;
    endfunction

    task automatic end_in_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_lanes(input string name, input lane_data_t exp, input lane_data_t act);
        if (act !== exp) begin
            $display("** Error %s: data expected %h, actual %h", name, exp, act);
            end_in_failure();
        end
    endtask

    task automatic check_meta(input string name,
                              input logic [nw_bits-1:0] exp_wid, input tmask_t exp_tmask,
                              input logic [nr_bits-1:0] exp_rd, input logic exp_wb,
                              input logic [nw_bits-1:0] act_wid, input tmask_t act_tmask,
                              input logic [nr_bits-1:0] act_rd, input logic act_wb);
        // printed as wid/tmask/rd/wb
        if ({act_wid, act_tmask, act_rd, act_wb} !== {exp_wid, exp_tmask, exp_rd, exp_wb}) begin
            $display("** Error %s: meta expected %h/%h/%h/%b, actual %h/%h/%h/%b", name,
                     exp_wid, exp_tmask, exp_rd, exp_wb, act_wid, act_tmask, act_rd, act_wb);
            end_in_failure();
        end
    endtask

    function automatic lane_data_t rand_lanes();
        lane_data_t v;
        for (int i = 0; i < num_threads; i++) begin
            v[i] = $random(seed);
        end
        return v;
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_req(input cry_op_t op, input logic [1:0] bs, input logic use_imm,
                            input logic [4:0] imm, input lane_data_t rs1, input lane_data_t rs2);
        exp_t e;
        logic ok;
        req_valid   = 1'b1;
        req_op      = op;
        req_bs      = bs;
        req_use_imm = use_imm;
        req_imm     = imm;
        req_rs1     = rs1;
        req_rs2     = rs2;
        req_pc      = next_pc;
        req_wid     = nw_bits'($random(seed));
        req_tmask   = num_threads'($random(seed));
        req_rd      = nr_bits'($random(seed));
        req_wb      = 1'($random(seed));
        e = '{data: cry_ref_result(op, bs, use_imm, imm, rs1, rs2), wid: req_wid,
              tmask: req_tmask, rd: req_rd, wb: req_wb && is_legal_op(op)};
        expected[next_pc] = e;
        exp_name[next_pc] = cur_test;
        accept_wait = 0;
        ok = 1'b0;
        while (!ok) begin
            #1;
            ok = req_ready;
            @(posedge clk);
            if (!ok) begin
                accept_wait++;
                if (accept_wait > 1000) begin
                    $display("timeout: req_ready stayed low for the request at pc %h", next_pc);
                    end_in_failure();
                end
                @(negedge clk);
            end
        end
        @(negedge clk);
        req_valid = 1'b0;
        next_pc   = next_pc + 4;
    endtask

    task automatic send_random(input cry_op_t op);
        send_req(op, 2'($random(seed)), 1'($random(seed)), 5'($random(seed)),
                 rand_lanes(), rand_lanes());
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected.num() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2000) begin
                $display("timeout: %0d results never reached the commit port", expected.num());
                end_in_failure();
            end
        end
    endtask

    task automatic compare_commit();
        exp_t e;
        if (!expected.exists(commit_pc)) begin
            $display("commit at pc %h that was never issued or already committed", commit_pc);
            end_in_failure();
        end else begin
            e = expected[commit_pc];
            check_lanes($sformatf("%s pc %h", exp_name[commit_pc], commit_pc), e.data,
                        commit_data);
            check_meta($sformatf("%s pc %h", exp_name[commit_pc], commit_pc), e.wid, e.tmask,
                       e.rd, e.wb, commit_wid, commit_tmask, commit_rd, commit_wb);
            expected.delete(commit_pc);
            exp_name.delete(commit_pc);
        end
    endtask

    // a result seen here transfers on the next rising edge
    initial begin
        forever begin
            @(negedge clk);
            #1;
            if (rst_n && commit_valid && commit_ready) begin
                compare_commit();
            end
        end
    end

    initial begin
        commit_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (backpressure) begin
                commit_ready = ($random(seed) % 3) != 0;
            end else begin
                commit_ready = 1'b1;
            end
        end
    end

    initial begin
        logic [3:0] code;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_op       = op_sha_sum0;
        req_bs       = '0;
        req_use_imm  = 1'b0;
        req_imm      = '0;
        req_wid      = '0;
        req_tmask    = '0;
        req_pc       = '0;
        req_rd       = '0;
        req_wb       = 1'b0;
        req_rs1      = '0;
        req_rs2      = '0;
        backpressure = 1'b0;
        next_pc      = 32'h0000_1000;
        cur_test     = "reset";
        build_sbox();
        if (sbox_tab[8'h00] != 8'h63 || sbox_tab[8'h01] != 8'h7c || sbox_tab[8'h53] != 8'hed) begin
            $display("reference S-box does not match the known AES table entries");
            end_in_failure();
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        cur_test = "sha256";
        for (int k = 0; k < 8; k++) begin
            send_random(op_sha_sum0);
            send_random(op_sha_sum1);
            send_random(op_sha_sig0);
            send_random(op_sha_sig1);
        end

        cur_test = "rotate";
        for (int k = 0; k < 8; k++) begin
            send_req(op_ror, 2'd0, 1'(k), 5'($random(seed)), rand_lanes(), rand_lanes());
            send_req(op_rol, 2'd0, 1'(k), 5'($random(seed)), rand_lanes(), rand_lanes());
        end
        send_req(op_ror, 2'd0, 1'b1, 5'd31, rand_lanes(), rand_lanes());
        send_req(op_rol, 2'd0, 1'b1, 5'd0, rand_lanes(), rand_lanes());

        cur_test = "aes32";
        for (int k = 0; k < 16; k++) begin
            send_req(op_aes_esi, 2'(k), 1'b0, 5'd0, rand_lanes(), rand_lanes());
            send_req(op_aes_esmi, 2'(k), 1'b0, 5'd0, rand_lanes(), rand_lanes());
        end

        cur_test = "illegal_op";
        for (int k = 8; k < 16; k++) begin
            send_random(cry_op_t'(4'(k)));
        end
        wait_drain();
        repeat (2) @(negedge clk);

        cur_test = "alu_latency";
        send_random(op_sha_sig1);
        if (accept_wait != 0 || !commit_valid || commit_pc != next_pc - 4) begin
            $display("ALU request on an idle unit did not commit on the next edge");
            end_in_failure();
        end

        cur_test = "mixed_backpressure";
        backpressure = 1'b1;
        for (int k = 0; k < 200; k++) begin
            code = 4'($random(seed));
            // upper codes mostly folded onto the aes ops, 8 stays illegal
            if (code > 4'd8) begin
                code = {3'b011, code[0]};
            end
            send_random(cry_op_t'(code));
            if ($random(seed) % 4 == 0) begin
                @(negedge clk);
            end
        end
        backpressure = 1'b0;
        wait_drain();
        repeat (4) @(negedge clk);

        if (expected.num() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("%0d results left without a commit", expected.num());
            end_in_failure();
        end
    end

endmodule

`default_nettype wire

//--- cry_unit.f
hw/cry_isa_pkg.sv
hw/cry_cfg_pkg.sv
hw/cry_pipe_reg.sv
hw/cry_req_decode.sv
hw/cry_sha_rot_unit.sv
hw/cry_aes_unit.sv
hw/cry_commit_stage.sv
hw/cry_unit.sv
test/cry_unit_properties.sv
test/cry_unit_tb.sv
